// ==== design/arena_pkg.sv ====
package arena_pkg;

    localparam int COORD_W = 12;
    localparam int RGB_W = 12;

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [RGB_W-1:0] rgb_t;
    typedef logic [1:0] slot_t;

    localparam int SLOT_COUNT = 4;

    // 800x600 raster, both syncs active high
    localparam int H_ACTIVE = 800;
    localparam int H_SYNC_START = 840;
    localparam int H_SYNC_END = 968;
    localparam int H_TOTAL = 1056;
    localparam int V_ACTIVE = 600;
    localparam int V_SYNC_START = 601;
    localparam int V_SYNC_END = 605;
    localparam int V_TOTAL = 628;

    localparam rgb_t BG_COLOR = 12'h124;
    localparam rgb_t SHAFT_COLOR = 12'hA85;
    localparam rgb_t TIP_COLOR = 12'hCCC;

    localparam int SPRITE_SIZE = 8;
    localparam int SPRITE_HALF = 4;
    localparam int SPEED = 4;
    localparam int DRAW_DELAY = 3;

    typedef rgb_t sprite_rom_t [SPRITE_SIZE*SPRITE_SIZE];

    // arrow pointing right, zero is transparent
    function automatic sprite_rom_t build_sprite();
        sprite_rom_t rom;
        for (int row = 0; row < SPRITE_SIZE; row++) begin
            for (int col = 0; col < SPRITE_SIZE; col++) begin
                rom[row*SPRITE_SIZE+col] = '0;
                if (row == 3 || row == 4) begin
                    rom[row*SPRITE_SIZE+col] = SHAFT_COLOR;
                end
                if (col == 7 && row >= 2 && row <= 5) begin
                    rom[row*SPRITE_SIZE+col] = TIP_COLOR;
                end
            end
        end
        return rom;
    endfunction

    localparam sprite_rom_t SPRITE_ROM = build_sprite();

endpackage

// ==== design/vga_timing.sv ====
module vga_timing
    import arena_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    output coord_t hcount,
    output coord_t vcount,
    output logic   hsync,
    output logic   vsync,
    output logic   hblnk,
    output logic   vblnk,
    output rgb_t   rgb
);

    coord_t h_cnt;
    coord_t v_cnt;
    logic   h_active;
    logic   v_active;

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == coord_t'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == coord_t'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign h_active = (h_cnt < H_ACTIVE);
    assign v_active = (v_cnt < V_ACTIVE);

    // decoded flags land one clock behind the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= '0;
        end else begin
            hcount <= h_cnt;
            vcount <= v_cnt;
            hsync  <= (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
            vsync  <= (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);
            hblnk  <= !h_active;
            vblnk  <= !v_active;
            rgb    <= (h_active && v_active) ? BG_COLOR : '0;
        end
    end

endmodule

// ==== design/projectile_table.sv ====
module projectile_table
    import arena_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          we,
    input  slot_t                         wr_slot,
    input  coord_t                        wr_x,
    input  coord_t                        wr_y,
    input  logic                          wr_dir,
    input  logic                          wr_active,
    output logic [SLOT_COUNT-1:0]         active,
    output logic [SLOT_COUNT-1:0]         dir,
    output logic [SLOT_COUNT*COORD_W-1:0] pos_x,
    output logic [SLOT_COUNT*COORD_W-1:0] pos_y
);

    coord_t x_q [SLOT_COUNT];
    coord_t y_q [SLOT_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= '0;
        end else if (we) begin
            active[wr_slot] <= wr_active;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            x_q[wr_slot] <= wr_x;
            y_q[wr_slot] <= wr_y;
            dir[wr_slot] <= wr_dir;
        end
    end

    // flatten per-slot coordinates for the readers
    always_comb begin
        for (int i = 0; i < SLOT_COUNT; i++) begin
            pos_x[i*COORD_W +: COORD_W] = x_q[i];
            pos_y[i*COORD_W +: COORD_W] = y_q[i];
        end
    end

endmodule

// ==== design/slot_write_arbiter.sv ====
module slot_write_arbiter
    import arena_pkg::*;
(
    input  logic   mv_req,
    input  slot_t  mv_slot,
    input  coord_t mv_x,
    input  coord_t mv_y,
    input  logic   mv_dir,
    input  logic   mv_active,
    output logic   mv_gnt,
    input  logic   ln_req,
    input  slot_t  ln_slot,
    input  coord_t ln_x,
    input  coord_t ln_y,
    input  logic   ln_dir,
    input  logic   ln_active,
    output logic   ln_gnt,
    output logic   we,
    output slot_t  wr_slot,
    output coord_t wr_x,
    output coord_t wr_y,
    output logic   wr_dir,
    output logic   wr_active
);

    // mover always wins, launcher waits
    assign mv_gnt = mv_req;
    assign ln_gnt = ln_req && !mv_req;
    assign we     = mv_req || ln_req;

    assign wr_slot   = mv_req ? mv_slot : ln_slot;
    assign wr_x      = mv_req ? mv_x : ln_x;
    assign wr_y      = mv_req ? mv_y : ln_y;
    assign wr_dir    = mv_req ? mv_dir : ln_dir;
    assign wr_active = mv_req ? mv_active : ln_active;

endmodule

// ==== design/projectile_launcher.sv ====
module projectile_launcher
    import arena_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fire_valid,
    input  coord_t                fire_x,
    input  coord_t                fire_y,
    input  logic                  fire_dir,
    output logic                  fire_ready,
    input  logic [SLOT_COUNT-1:0] active,
    output logic                  req,
    output slot_t                 wr_slot,
    output coord_t                wr_x,
    output coord_t                wr_y,
    output logic                  wr_dir,
    output logic                  wr_active,
    input  logic                  gnt
);

    typedef enum logic [1:0] {IDLE, WRITE, SETTLE} state_t;

    state_t state;
    slot_t  free_slot;
    logic   any_free;
    logic   accept;

    // lowest inactive slot
    always_comb begin
        free_slot = '0;
        any_free  = 1'b0;
        for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
            if (!active[i]) begin
                free_slot = slot_t'(i);
                any_free  = 1'b1;
            end
        end
    end

    assign accept = fire_valid && fire_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            fire_ready <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state      <= WRITE;
                        fire_ready <= 1'b0;
                    end else begin
                        fire_ready <= any_free;
                    end
                end
                WRITE: begin
                    if (gnt) begin
                        state <= SETTLE;
                    end
                end
                // active vector already shows the new slot here
                SETTLE: begin
                    state      <= IDLE;
                    fire_ready <= any_free;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_slot <= free_slot;
            wr_x    <= fire_x;
            wr_y    <= fire_y;
            wr_dir  <= fire_dir;
        end
    end

    assign req       = (state == WRITE);
    assign wr_active = 1'b1;

endmodule

// ==== design/projectile_mover.sv ====
module projectile_mover
    import arena_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          vblnk,
    input  logic [SLOT_COUNT-1:0]         active,
    input  logic [SLOT_COUNT-1:0]         dir,
    input  logic [SLOT_COUNT*COORD_W-1:0] pos_x,
    input  logic [SLOT_COUNT*COORD_W-1:0] pos_y,
    output logic                          req,
    output slot_t                         wr_slot,
    output coord_t                        wr_x,
    output coord_t                        wr_y,
    output logic                          wr_dir,
    output logic                          wr_active,
    input  logic                          gnt
);

    typedef enum logic [1:0] {IDLE, SCAN, WRITE} state_t;

    state_t           state;
    slot_t            idx;
    logic             vblnk_q;
    logic             last_slot;
    coord_t           cur_x;
    logic [COORD_W:0] x_right;
    logic             retire;

    assign cur_x     = pos_x[idx*COORD_W +: COORD_W];
    assign x_right   = {1'b0, cur_x} + (COORD_W + 1)'(SPEED);
    assign last_slot = (idx == slot_t'(SLOT_COUNT - 1));

    // off the left edge or at/past the right edge
    assign retire = dir[idx] ? (x_right >= H_ACTIVE) : (cur_x < SPEED);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            idx     <= '0;
            vblnk_q <= 1'b0;
        end else begin
            vblnk_q <= vblnk;
            case (state)
                IDLE: begin
                    if (vblnk && !vblnk_q) begin
                        state <= SCAN;
                        idx   <= '0;
                    end
                end
                SCAN: begin
                    if (active[idx]) begin
                        state <= WRITE;
                    end else if (last_slot) begin
                        state <= IDLE;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                WRITE: begin
                    if (gnt) begin
                        state <= last_slot ? IDLE : SCAN;
                        idx   <= last_slot ? idx : idx + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // latch the update while the slot is being looked at
    always_ff @(posedge clk) begin
        if (state == SCAN && active[idx]) begin
            wr_slot   <= idx;
            wr_x      <= dir[idx] ? x_right[COORD_W-1:0] : cur_x - coord_t'(SPEED);
            wr_y      <= pos_y[idx*COORD_W +: COORD_W];
            wr_dir    <= dir[idx];
            wr_active <= !retire;
        end
    end

    assign req = (state == WRITE);

endmodule

// ==== design/projectile_draw.sv ====
module projectile_draw
    import arena_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          game_active,
    input  logic [SLOT_COUNT-1:0]         active,
    input  logic [SLOT_COUNT-1:0]         dir,
    input  logic [SLOT_COUNT*COORD_W-1:0] pos_x,
    input  logic [SLOT_COUNT*COORD_W-1:0] pos_y,
    input  coord_t                        hcount_in,
    input  coord_t                        vcount_in,
    input  logic                          hsync_in,
    input  logic                          vsync_in,
    input  logic                          hblnk_in,
    input  logic                          vblnk_in,
    input  rgb_t                          rgb_in,
    output coord_t                        hcount_out,
    output coord_t                        vcount_out,
    output logic                          hsync_out,
    output logic                          vsync_out,
    output logic                          hblnk_out,
    output logic                          vblnk_out,
    output rgb_t                          rgb_out
);

    coord_t     px;
    coord_t     py;
    coord_t     rel_x;
    coord_t     rel_y;
    logic [2:0] col;
    rgb_t       pix;
    rgb_t       rgb_nxt;

    // delay line, index DRAW_DELAY-1 drives the outputs
    rgb_t       rgb_d [DRAW_DELAY];
    logic [3:0] sync_d [DRAW_DELAY];
    coord_t     hcount_d [DRAW_DELAY];
    coord_t     vcount_d [DRAW_DELAY];

    always_comb begin
        rgb_nxt = rgb_in;
        px      = '0;
        py      = '0;
        rel_x   = '0;
        rel_y   = '0;
        col     = '0;
        pix     = '0;
        if (game_active && !hblnk_in && !vblnk_in) begin
            // later slots overwrite earlier ones
            for (int i = 0; i < SLOT_COUNT; i++) begin
                px = pos_x[i*COORD_W +: COORD_W];
                py = pos_y[i*COORD_W +: COORD_W];
                if (active[i] &&
                    hcount_in + coord_t'(SPRITE_HALF) >= px &&
                    hcount_in < px + coord_t'(SPRITE_HALF) &&
                    vcount_in + coord_t'(SPRITE_HALF) >= py &&
                    vcount_in < py + coord_t'(SPRITE_HALF)) begin
                    rel_x = hcount_in + coord_t'(SPRITE_HALF) - px;
                    rel_y = vcount_in + coord_t'(SPRITE_HALF) - py;
                    // left-flying arrows are mirrored
                    col = dir[i] ? rel_x[2:0] : 3'd7 - rel_x[2:0];
                    pix = SPRITE_ROM[{rel_y[2:0], col}];
                    if (pix != '0) begin
                        rgb_nxt = pix;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DRAW_DELAY; i++) begin
                rgb_d[i]  <= '0;
                sync_d[i] <= '0;
            end
        end else begin
            rgb_d[0]  <= rgb_nxt;
            sync_d[0] <= {hsync_in, vsync_in, hblnk_in, vblnk_in};
            for (int i = 1; i < DRAW_DELAY; i++) begin
                rgb_d[i]  <= rgb_d[i-1];
                sync_d[i] <= sync_d[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        hcount_d[0] <= hcount_in;
        vcount_d[0] <= vcount_in;
        for (int i = 1; i < DRAW_DELAY; i++) begin
            hcount_d[i] <= hcount_d[i-1];
            vcount_d[i] <= vcount_d[i-1];
        end
    end

    assign rgb_out    = rgb_d[DRAW_DELAY-1];
    assign hcount_out = hcount_d[DRAW_DELAY-1];
    assign vcount_out = vcount_d[DRAW_DELAY-1];
    assign {hsync_out, vsync_out, hblnk_out, vblnk_out} = sync_d[DRAW_DELAY-1];

endmodule

// ==== design/arena_top.sv ====
module arena_top
    import arena_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   game_active,
    input  logic   fire_valid,
    input  coord_t fire_x,
    input  coord_t fire_y,
    input  logic   fire_dir,
    output logic   fire_ready,
    output coord_t hcount,
    output coord_t vcount,
    output logic   hsync,
    output logic   vsync,
    output logic   hblnk,
    output logic   vblnk,
    output rgb_t   rgb
);

    // raster from the timing generator
    coord_t t_hcount;
    coord_t t_vcount;
    logic   t_hsync;
    logic   t_vsync;
    logic   t_hblnk;
    logic   t_vblnk;
    rgb_t   t_rgb;

    // table state
    logic [SLOT_COUNT-1:0]         active;
    logic [SLOT_COUNT-1:0]         dir;
    logic [SLOT_COUNT*COORD_W-1:0] pos_x;
    logic [SLOT_COUNT*COORD_W-1:0] pos_y;

    // engine requests and the shared write bus
    logic   mv_req, mv_gnt, mv_dir, mv_active;
    slot_t  mv_slot;
    coord_t mv_x, mv_y;
    logic   ln_req, ln_gnt, ln_dir, ln_active;
    slot_t  ln_slot;
    coord_t ln_x, ln_y;
    logic   we, wr_dir, wr_active;
    slot_t  wr_slot;
    coord_t wr_x, wr_y;

    vga_timing u_vga_timing (
        .clk, .rst,
        .hcount(t_hcount), .vcount(t_vcount),
        .hsync(t_hsync), .vsync(t_vsync),
        .hblnk(t_hblnk), .vblnk(t_vblnk),
        .rgb(t_rgb)
    );

    projectile_table u_table (
        .clk, .rst, .we, .wr_slot, .wr_x, .wr_y, .wr_dir, .wr_active,
        .active, .dir, .pos_x, .pos_y
    );

    slot_write_arbiter u_arbiter (
        .mv_req, .mv_slot, .mv_x, .mv_y, .mv_dir, .mv_active, .mv_gnt,
        .ln_req, .ln_slot, .ln_x, .ln_y, .ln_dir, .ln_active, .ln_gnt,
        .we, .wr_slot, .wr_x, .wr_y, .wr_dir, .wr_active
    );

    projectile_launcher u_launcher (
        .clk, .rst, .fire_valid, .fire_x, .fire_y, .fire_dir, .fire_ready,
        .active,
        .req(ln_req), .wr_slot(ln_slot), .wr_x(ln_x), .wr_y(ln_y),
        .wr_dir(ln_dir), .wr_active(ln_active), .gnt(ln_gnt)
    );

    projectile_mover u_mover (
        .clk, .rst, .vblnk(t_vblnk), .active, .dir, .pos_x, .pos_y,
        .req(mv_req), .wr_slot(mv_slot), .wr_x(mv_x), .wr_y(mv_y),
        .wr_dir(mv_dir), .wr_active(mv_active), .gnt(mv_gnt)
    );

    projectile_draw u_draw (
        .clk, .rst, .game_active, .active, .dir, .pos_x, .pos_y,
        .hcount_in(t_hcount), .vcount_in(t_vcount),
        .hsync_in(t_hsync), .vsync_in(t_vsync),
        .hblnk_in(t_hblnk), .vblnk_in(t_vblnk), .rgb_in(t_rgb),
        .hcount_out(hcount), .vcount_out(vcount),
        .hsync_out(hsync), .vsync_out(vsync),
        .hblnk_out(hblnk), .vblnk_out(vblnk), .rgb_out(rgb)
    );

endmodule

// ==== testbench/arena_tb.sv ====
module arena_tb
    import arena_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 6 * H_TOTAL * V_TOTAL + 1000;
    localparam int LAUNCH_GAP = 20;
    localparam int READY_WAIT = 64;
    localparam int HOLD_CYCLES = 200;

    logic   clk;
    logic   rst;
    logic   game_active;
    logic   fire_valid;
    coord_t fire_x;
    coord_t fire_y;
    logic   fire_dir;
    logic   fire_ready;
    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
    rgb_t   rgb;

    // reference slot list built from accepted handshakes
    logic  m_active [SLOT_COUNT];
    logic  m_dir [SLOT_COUNT];
    int    m_x [SLOT_COUNT];
    int    m_y [SLOT_COUNT];
    int    used_slots;
    rgb_t  exp_rgb;
    int    exp_h;
    int    exp_v;
    int    last_h;
    int    last_v;
    logic  vblnk_prev;
    logic  checks_on;
    logic  hold_full;
    int    cycle_count;
    string test_name;

    arena_top DUT (
        .clk, .rst, .game_active,
        .fire_valid, .fire_x, .fire_y, .fire_dir, .fire_ready,
        .hcount, .vcount, .hsync, .vsync, .hblnk, .vblnk, .rgb
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_mismatch(input string sig, input int expected, input int actual);
        $display("mismatch in %s (%s): expected %0h, actual %0h", test_name, sig, expected, actual);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("error in %s: %s", test_name, msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    function automatic logic in_range(input int val, input int lo, input int hi);
        return (val >= lo) && (val < hi);
    endfunction

    // unmirrored arrow with the tip on the right
    function automatic rgb_t arrow_pixel(input int row, input int col);
        if (col == SPRITE_SIZE - 1 && row >= 2 && row <= 5) begin
            return TIP_COLOR;
        end
        if (row == 3 || row == 4) begin
            return SHAFT_COLOR;
        end
        return '0;
    endfunction

    function automatic rgb_t model_pixel(input int h, input int v);
        rgb_t c;
        rgb_t s;
        int   col;
        int   row;
        if (h >= H_ACTIVE || v >= V_ACTIVE) begin
            return '0;
        end
        c = BG_COLOR;
        if (!game_active) begin
            return c;
        end
        // higher slots are painted last
        for (int i = 0; i < SLOT_COUNT; i++) begin
            if (m_active[i] && in_range(h, m_x[i] - SPRITE_HALF, m_x[i] + SPRITE_HALF) &&
                in_range(v, m_y[i] - SPRITE_HALF, m_y[i] + SPRITE_HALF)) begin
                col = h - m_x[i] + SPRITE_HALF;
                row = v - m_y[i] + SPRITE_HALF;
                if (!m_dir[i]) begin
                    col = SPRITE_SIZE - 1 - col;
                end
                s = arrow_pixel(row, col);
                if (s != '0) begin
                    c = s;
                end
            end
        end
        return c;
    endfunction

    task automatic add_model_slot(input int x, input int y, input logic right);
        int slot;
        slot = -1;
        for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
            if (!m_active[i]) begin
                slot = i;
            end
        end
        if (slot < 0) begin
            report_failure("a launch was accepted but the model has no free slot");
        end else begin
            m_active[slot] = 1'b1;
            m_dir[slot] = right;
            m_x[slot] = x;
            m_y[slot] = y;
            used_slots++;
        end
    endtask

    // one frame step that retires slots leaving the screen
    task automatic advance_model();
        int nx;
        for (int i = 0; i < SLOT_COUNT; i++) begin
            if (m_active[i]) begin
                nx = m_dir[i] ? m_x[i] + SPEED : m_x[i] - SPEED;
                if (nx < 0 || nx >= H_ACTIVE) begin
                    m_active[i] = 1'b0;
                    used_slots--;
                end else begin
                    m_x[i] = nx;
                end
            end
        end
    endtask

    task automatic wait_for_ready(input string what);
        int waited;
        waited = 0;
        while (!fire_ready) begin
            if (waited == READY_WAIT) begin
                report_failure({"fire_ready did not go high ", what});
            end else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    // the handshake completes on the posedge after ready is seen
    task automatic launch(input int x, input int y, input logic right);
        fire_x = coord_t'(x);
        fire_y = coord_t'(y);
        fire_dir = right;
        fire_valid = 1'b1;
        wait_for_ready("for a launch");
        @(negedge clk);
        add_model_slot(x, y, right);
        fire_valid = 1'b0;
    endtask

    task automatic wait_launch_window();
        @(posedge vblnk);
        repeat (LAUNCH_GAP) @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (vblnk && !vblnk_prev) begin
            advance_model();
        end
        vblnk_prev = vblnk;
        // raster position one clock after the last one seen
        if (last_h == H_TOTAL - 1) begin
            exp_h = 0;
            exp_v = (last_v == V_TOTAL - 1) ? 0 : last_v + 1;
        end else begin
            exp_h = last_h + 1;
            exp_v = last_v;
        end
        last_h = int'(hcount);
        last_v = int'(vcount);
        exp_rgb = model_pixel(int'(hcount), int'(vcount));
    end

    always @(posedge clk) begin
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("the run did not finish before the cycle limit");
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    hcount_chk: assert property (@(posedge clk) checks_on |-> (int'(hcount) == exp_h))
        else report_mismatch("hcount", $sampled(exp_h), $sampled(hcount));

    vcount_chk: assert property (@(posedge clk) checks_on |-> (int'(vcount) == exp_v))
        else report_mismatch("vcount", $sampled(exp_v), $sampled(vcount));

    hsync_chk: assert property (@(posedge clk)
        checks_on |-> (hsync == in_range(hcount, H_SYNC_START, H_SYNC_END)))
        else report_mismatch("hsync", in_range($sampled(hcount), H_SYNC_START, H_SYNC_END),
                             $sampled(hsync));

    vsync_chk: assert property (@(posedge clk)
        checks_on |-> (vsync == in_range(vcount, V_SYNC_START, V_SYNC_END)))
        else report_mismatch("vsync", in_range($sampled(vcount), V_SYNC_START, V_SYNC_END),
                             $sampled(vsync));

    hblnk_chk: assert property (@(posedge clk)
        checks_on |-> (hblnk == (hcount >= H_ACTIVE)))
        else report_mismatch("hblnk", $sampled(hcount) >= H_ACTIVE, $sampled(hblnk));

    vblnk_chk: assert property (@(posedge clk)
        checks_on |-> (vblnk == (vcount >= V_ACTIVE)))
        else report_mismatch("vblnk", $sampled(vcount) >= V_ACTIVE, $sampled(vblnk));

    rgb_chk: assert property (@(posedge clk) checks_on |-> (rgb == exp_rgb))
        else report_mismatch("rgb", $sampled(exp_rgb), $sampled(rgb));

    full_chk: assert property (@(posedge clk) hold_full |-> !fire_ready)
        else report_mismatch("fire_ready", 0, $sampled(fire_ready));

    accept_chk: assert property (@(posedge clk)
        (fire_valid && fire_ready) |-> (used_slots < SLOT_COUNT))
        else report_failure("a launch was accepted while every slot was in use");

    initial begin
        void'($urandom(87723));
        rst = 1'b1;
        game_active = 1'b1;
        fire_valid = 1'b0;
        fire_x = '0;
        fire_y = '0;
        fire_dir = 1'b0;
        checks_on = 1'b0;
        hold_full = 1'b0;
        vblnk_prev = 1'b0;
        exp_rgb = '0;
        exp_h = 0;
        exp_v = 0;
        last_h = 0;
        last_v = 0;
        cycle_count = 0;
        used_slots = 0;
        test_name = "sync and blanking";
        for (int i = 0; i < SLOT_COUNT; i++) begin
            m_active[i] = 1'b0;
            m_dir[i] = 1'b0;
            m_x[i] = 0;
            m_y[i] = 0;
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        // let the raster pipeline fill before comparing
        repeat (8) @(negedge clk);
        checks_on = 1'b1;

        wait_launch_window();
        test_name = "drawing and mirroring";
        launch(50 + int'($urandom % 650), 20 + int'($urandom % 560), 1'b1);
        launch(50 + int'($urandom % 650), 20 + int'($urandom % 560), 1'b0);

        wait_launch_window();
        test_name = "back-pressure";
        launch(796, 20 + int'($urandom % 560), 1'b1);
        launch(50 + int'($urandom % 650), 20 + int'($urandom % 560), 1'($urandom % 2));
        hold_full = 1'b1;
        fire_x = coord_t'(400);
        fire_y = coord_t'(300);
        fire_valid = 1'b1;
        repeat (HOLD_CYCLES) @(negedge clk);
        fire_valid = 1'b0;
        hold_full = 1'b0;
        test_name = "per-frame movement";

        wait_launch_window();
        test_name = "retirement";
        wait_for_ready("after the retirement");

        wait_launch_window();
        test_name = "game_active low";
        game_active = 1'b0;

        wait_launch_window();
        test_name = "movement after game_active low";
        game_active = 1'b1;

        @(posedge vblnk);
        @(negedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
design/arena_pkg.sv
design/vga_timing.sv
design/projectile_table.sv
design/slot_write_arbiter.sv
design/projectile_launcher.sv
design/projectile_mover.sv
design/projectile_draw.sv
design/arena_top.sv
testbench/arena_tb.sv

// ==== Bender.yml ====
package:
  name: arena_projectiles

sources:
  - files:
      - design/arena_pkg.sv
      - design/vga_timing.sv
      - design/projectile_table.sv
      - design/slot_write_arbiter.sv
      - design/projectile_launcher.sv
      - design/projectile_mover.sv
      - design/projectile_draw.sv
      - design/arena_top.sv
  - target: test
    files:
      - testbench/arena_tb.sv
